/* files.f */
+incdir+common
+incdir+verification
common/cache_pkg.sv
common/mem_bus_pkg.sv
cache/cache_store.sv
cache/cache_controller.sv
logic/apb_data_memory.sv
logic/dmem_subsystem.sv
verification/tb_dmem_subsystem.sv

/* Makefile */
# Verilator build and run for the data memory subsystem testbench

TOP := tb_dmem_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -Mdir obj_dir

# the log decides pass or fail
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/tb_dmem_model.svh */
// reference byte memory, cache state model and compare tasks for the data memory testbench
`ifndef TB_DMEM_MODEL_SVH
`define TB_DMEM_MODEL_SVH

`include "dmem_params.svh"

localparam int MODEL_BYTES = 2 ** `DMEM_ADDR_BITS;

logic [7:0]                ref_mem   [MODEL_BYTES];
logic                      ref_valid [`DMEM_SETS][2];
logic [`DMEM_TAG_BITS-1:0] ref_tag   [`DMEM_SETS][2];
logic                      ref_lru   [`DMEM_SETS];
int                        mismatch_count;
int                        check_count;

// memory starts from the address pattern, cache starts empty
task automatic model_reset();
    logic [31:0] word;
    logic [16:0] a;
    logic [7:0]  s;
    for (int i = 0; i < MODEL_BYTES; i++) begin
        a = 17'(i);
        word = {15'd0, a[16:2], 2'b00} ^ `DMEM_INIT_PATTERN;
        ref_mem[a] = word[8*a[1:0] +: 8];
    end
    for (int i = 0; i < `DMEM_SETS; i++) begin
        s = 8'(i);
        ref_valid[s][0] = 1'b0;
        ref_valid[s][1] = 1'b0;
        ref_lru[s] = 1'b0;
    end
    mismatch_count = 0;
    check_count = 0;
endtask

function automatic logic expect_hit(logic [16:0] a);
    logic [7:0] s;
    s = a[10:3];
    return (ref_valid[s][0] && ref_tag[s][0] == a[16:11]) ||
           (ref_valid[s][1] && ref_tag[s][1] == a[16:11]);
endfunction

// whole aligned word, little endian
function automatic logic [31:0] expect_word(logic [16:0] a);
    logic [16:0] base;
    base = {a[16:2], 2'b00};
    return {ref_mem[base + 17'd3], ref_mem[base + 17'd2],
            ref_mem[base + 17'd1], ref_mem[base]};
endfunction

// miss allocates into the lru way, any completed access makes its way most recent
function automatic void model_access(core_req_t r);
    logic [16:0] a;
    logic [16:0] base;
    logic [16:0] idx;
    logic [7:0]  s;
    logic        way;
    int          nbytes;
    a = r.addr[16:0];
    s = a[10:3];
    if (ref_valid[s][0] && ref_tag[s][0] == a[16:11]) begin
        way = 1'b0;
    end else if (ref_valid[s][1] && ref_tag[s][1] == a[16:11]) begin
        way = 1'b1;
    end else begin
        way = ref_lru[s];
        ref_valid[s][way] = 1'b1;
        ref_tag[s][way] = a[16:11];
    end
    ref_lru[s] = ~way;
    if (r.write) begin
        nbytes = (r.size == MEM_BYTE) ? 1 : ((r.size == MEM_HALF) ? 2 : 4);
        base = a & ~17'(nbytes - 1);
        for (int k = 0; k < nbytes; k++) begin
            idx = base + 17'(k);
            ref_mem[idx] = r.wdata[k*8 +: 8];
        end
    end
endfunction

task automatic check_word(core_req_t r, logic [31:0] got, logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH t=%0t: read of 0x%05h returned %08h, expected %08h",
                 $time, r.addr[16:0], got, exp);
    end
endtask

task automatic check_hit(core_req_t r, logic exp_stall, logic got_stall);
    check_count++;
    if (got_stall !== exp_stall) begin
        mismatch_count++;
        $display("MISMATCH t=%0t: stall in request cycle of 0x%05h (write %0b) is %0b, expected %0b",
                 $time, r.addr[16:0], r.write, got_stall, exp_stall);
    end
endtask

`endif

/* verification/tb_dmem_subsystem.sv */
// testbench for the data memory subsystem with a reference model and a result checker
`timescale 1ns/1ps
`default_nettype none

`include "dmem_params.svh"

module tb_dmem_subsystem
    import mem_bus_pkg::*;
();

    localparam int DIRECTED_OPS = 29;
    localparam int RANDOM_OPS   = 300;
    localparam int CYCLE_LIMIT  = 40 * (DIRECTED_OPS + RANDOM_OPS) + 200;
    localparam logic [7:0] RAND_SETS [4] = '{8'h10, 8'h11, 8'h55, 8'hA0};
    localparam logic [5:0] RAND_TAGS [4] = '{6'h00, 6'h07, 6'h1C, 6'h3F};

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    core_req_t   req;
    logic        stall;
    logic [31:0] rdata;

    logic        exp_stall_q [$];
    logic [31:0] exp_word_q [$];
    logic        first_cycle;
    logic        req_done;
    int          cycle_count;
    int          tests_run;
    int          tests_failed;

    `include "tb_dmem_model.svh"

    dmem_subsystem u_dmem_subsystem (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .stall     (stall),
        .rdata     (rdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // results are sampled mid-cycle where stall and rdata are settled
    always @(negedge clk) begin
        if (rst_n && req_valid) begin
            if (exp_stall_q.size() == 0) begin
                mismatch_count++;
                $display("checker saw a request with no expected result queued");
            end else begin
                if (first_cycle) begin
                    check_hit(req, exp_stall_q[0], stall);
                    first_cycle = 1'b0;
                end
                if (!stall) begin
                    if (!req.write) begin
                        check_word(req, rdata, exp_word_q[0]);
                    end
                    void'(exp_stall_q.pop_front());
                    void'(exp_word_q.pop_front());
                    req_done = 1'b1;
                end
            end
        end
    end

    // expectations come from the model before it takes the access
    task automatic issue(input core_req_t r);
        exp_stall_q.push_back(r.write ? 1'b1 : !expect_hit(r.addr[16:0]));
        exp_word_q.push_back(expect_word(r.addr[16:0]));
        model_access(r);
        req         = r;
        req_valid   = 1'b1;
        first_cycle = 1'b1;
        req_done    = 1'b0;
        do begin
            @(posedge clk);
        end while (!req_done);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic read_word(input logic [16:0] addr);
        core_req_t r;
        r.addr  = {15'd0, addr[16:2], 2'b00};
        r.wdata = 32'd0;
        r.size  = MEM_WORD;
        r.write = 1'b0;
        issue(r);
    endtask

    task automatic write_data(input logic [16:0] addr, input mem_size_e size,
                              input logic [31:0] data);
        core_req_t r;
        r.addr  = {15'd0, addr};
        r.wdata = data;
        r.size  = size;
        r.write = 1'b1;
        issue(r);
    endtask

    function automatic logic [16:0] line_addr(logic [5:0] tag, logic [7:0] idx, logic [2:0] off);
        return {tag, idx, off};
    endfunction

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (mismatch_count != errors_before) begin
            tests_failed++;
            $display("test %0d %s: fail, %0d mismatches", tests_run, name,
                     mismatch_count - errors_before);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    initial begin
        int          errs;
        logic [16:0] addr;
        mem_size_e   size;
        void'($urandom(32'h6283_d24b));
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        first_cycle  = 1'b0;
        req_done     = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        model_reset();
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        errs = mismatch_count;
        read_word(17'h00100);
        read_word(17'h04104);
        read_word(17'h1FFF8);
        finish_test("cold reads", errs);

        errs = mismatch_count;
        read_word(17'h00100);
        read_word(17'h00104);
        read_word(17'h04100);
        read_word(17'h1FFFC);
        finish_test("read hits", errs);

        // first three hit, last three allocate
        errs = mismatch_count;
        write_data(17'h00101, MEM_BYTE, 32'h0000_00A5);
        read_word(17'h00100);
        write_data(17'h04106, MEM_HALF, 32'h0000_BEEF);
        read_word(17'h04104);
        write_data(17'h1FFF8, MEM_WORD, 32'hC001_D00D);
        read_word(17'h1FFF8);
        write_data(17'h08202, MEM_BYTE, 32'h0000_003C);
        read_word(17'h08200);
        write_data(17'h0A30C, MEM_WORD, 32'h1234_5678);
        read_word(17'h0A30C);
        write_data(17'h0C012, MEM_HALF, 32'h0000_7E81);
        read_word(17'h0C010);
        finish_test("write merge", errs);

        errs = mismatch_count;
        read_word(line_addr(6'h01, 8'h55, 3'd0));
        read_word(line_addr(6'h12, 8'h55, 3'd0));
        read_word(line_addr(6'h01, 8'h55, 3'd4));
        read_word(line_addr(6'h2A, 8'h55, 3'd0));
        read_word(line_addr(6'h01, 8'h55, 3'd0));
        read_word(line_addr(6'h12, 8'h55, 3'd4));
        finish_test("lru replacement", errs);

        errs = mismatch_count;
        write_data(line_addr(6'h05, 8'h9A, 3'd4), MEM_WORD, 32'hA1B2_C3D4);
        read_word(line_addr(6'h15, 8'h9A, 3'd0));
        read_word(line_addr(6'h25, 8'h9A, 3'd0));
        read_word(line_addr(6'h05, 8'h9A, 3'd4));
        finish_test("write through", errs);

        errs = mismatch_count;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            addr = line_addr(RAND_TAGS[2'($urandom_range(3))], RAND_SETS[2'($urandom_range(3))],
                             3'($urandom_range(7)));
            size = mem_size_e'(2'($urandom_range(2)));
            if (size == MEM_HALF) begin
                addr[0] = 1'b0;
            end else if (size == MEM_WORD) begin
                addr[1:0] = 2'b00;
            end
            if ($urandom_range(1) == 1) begin
                write_data(addr, size, $urandom());
            end else begin
                read_word(addr);
            end
        end
        finish_test("random traffic", errs);

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 tests_run, tests_failed, check_count, mismatch_count);
        if (mismatch_count == 0 && tests_failed == 0 && exp_stall_q.size() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/dmem_subsystem.sv */
// data memory subsystem top joining cache controller, cache store and APB RAM
`timescale 1ns/1ps
`default_nettype none

`include "dmem_params.svh"

module dmem_subsystem
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      req_valid,
    input  wire core_req_t req,
    output logic           stall,
    output logic [31:0]    rdata
);

    logic [`DMEM_ADDR_BITS-1:0]    lookup_addr;
    cache_lookup_t                 lookup;
    logic                          fill_en;
    logic                          fill_way;
    logic [`DMEM_LINE_BYTES*8-1:0] fill_data;
    logic                          wr_en;
    logic                          wr_way;
    logic [`DMEM_LINE_BYTES-1:0]   wr_strb;
    logic [`DMEM_LINE_BYTES*8-1:0] wr_data;
    logic                          touch_en;
    apb_req_t                      apb_req;
    apb_rsp_t                      apb_rsp;

    cache_controller u_cache_controller (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .stall       (stall),
        .rdata       (rdata),
        .lookup_addr (lookup_addr),
        .lookup      (lookup),
        .fill_en     (fill_en),
        .fill_way    (fill_way),
        .fill_data   (fill_data),
        .wr_en       (wr_en),
        .wr_way      (wr_way),
        .wr_strb     (wr_strb),
        .wr_data     (wr_data),
        .touch_en    (touch_en),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp)
    );

    cache_store u_cache_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_addr (lookup_addr),
        .lookup      (lookup),
        .fill_en     (fill_en),
        .fill_way    (fill_way),
        .fill_data   (fill_data),
        .wr_en       (wr_en),
        .wr_way      (wr_way),
        .wr_strb     (wr_strb),
        .wr_data     (wr_data),
        .touch_en    (touch_en)
    );

    apb_data_memory u_apb_data_memory (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

endmodule

`default_nettype wire

/* logic/apb_data_memory.sv */
// APB completer RAM with byte strobes and one wait state
`timescale 1ns/1ps
`default_nettype none

`include "dmem_params.svh"

module apb_data_memory
    import mem_bus_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire apb_req_t apb_req,
    output apb_rsp_t      apb_rsp
);

    localparam int WORD_BITS = `DMEM_ADDR_BITS - 2;
    localparam int MEM_WORDS = 2 ** WORD_BITS;

    logic [31:0] mem [MEM_WORDS];

    logic [WORD_BITS-1:0] word_idx;
    logic                 access;
    logic                 wait_q;
    logic [31:0]          rdata_q;

    // fixed pattern stands in for a preload
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (32'(i) << 2) ^ `DMEM_INIT_PATTERN;
        end
    end

    assign word_idx = apb_req.paddr[`DMEM_ADDR_BITS-1:2];
    assign access   = apb_req.psel && apb_req.penable;

    assign apb_rsp.pready = access && wait_q;
    assign apb_rsp.prdata = rdata_q;

    // first access cycle is the wait state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= access && !wait_q;
        end
    end

    always_ff @(posedge clk) begin
        if (access && !wait_q) begin
            rdata_q <= mem[word_idx];
        end
        if (apb_rsp.pready && apb_req.pwrite) begin
            for (int b = 0; b < 4; b++) begin
                if (apb_req.pstrb[b]) mem[word_idx][b*8 +: 8] <= apb_req.pwdata[b*8 +: 8];
            end
        end
    end

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.penable |-> apb_req.psel);

endmodule

`default_nettype wire

/* cache/cache_controller.sv */
// data cache FSM for line fills and write-through, acting as APB requester
`timescale 1ns/1ps
`default_nettype none

`include "dmem_params.svh"

module cache_controller
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            req_valid,
    input  wire core_req_t                       req,
    output logic                                 stall,
    output logic [31:0]                          rdata,
    output logic [`DMEM_ADDR_BITS-1:0]           lookup_addr,
    input  wire cache_lookup_t                   lookup,
    output logic                                 fill_en,
    output logic                                 fill_way,
    output logic [`DMEM_LINE_BYTES*8-1:0]        fill_data,
    output logic                                 wr_en,
    output logic                                 wr_way,
    output logic [`DMEM_LINE_BYTES-1:0]          wr_strb,
    output logic [`DMEM_LINE_BYTES*8-1:0]        wr_data,
    output logic                                 touch_en,
    output apb_req_t                             apb_req,
    input  wire apb_rsp_t                        apb_rsp
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FILL_LO,
        ST_FILL_HI,
        ST_INSTALL,
        ST_WRITE
    } state_e;

    state_e      state_q;
    state_e      state_d;
    logic        access_q;
    logic        wr_done_q;
    logic        xfer_done;
    logic [31:0] line_lo_q;
    logic [31:0] line_hi_q;
    logic [3:0]  strb4;
    logic [31:0] lane_data;

    assign lookup_addr = req.addr[`DMEM_ADDR_BITS-1:0];
    assign rdata       = lookup.word;
    assign fill_way    = lookup.hit_way;
    assign fill_data   = {line_hi_q, line_lo_q};
    assign wr_way      = lookup.hit_way;
    assign xfer_done   = apb_req.psel && apb_req.penable && apb_rsp.pready;

    // place right-aligned core data into its byte lanes
    always_comb begin
        case (req.size)
            MEM_BYTE: begin
                strb4     = 4'b0001 << req.addr[1:0];
                lane_data = {4{req.wdata[7:0]}};
            end
            MEM_HALF: begin
                strb4     = 4'b0011 << {req.addr[1], 1'b0};
                lane_data = {2{req.wdata[15:0]}};
            end
            default: begin
                strb4     = 4'b1111;
                lane_data = req.wdata;
            end
        endcase
    end

    assign wr_strb = req.addr[2] ? {strb4, 4'b0000} : {4'b0000, strb4};
    assign wr_data = {lane_data, lane_data};

    always_comb begin
        apb_req.psel    = (state_q == ST_FILL_LO) || (state_q == ST_FILL_HI) ||
                          (state_q == ST_WRITE);
        apb_req.penable = access_q;
        apb_req.pwrite  = (state_q == ST_WRITE);
        if (state_q == ST_WRITE) begin
            apb_req.paddr = {req.addr[`DMEM_ADDR_BITS-1:2], 2'b00};
        end else begin
            apb_req.paddr = {req.addr[`DMEM_ADDR_BITS-1:3], state_q == ST_FILL_HI, 2'b00};
        end
        apb_req.pwdata  = lane_data;
        apb_req.pstrb   = apb_req.pwrite ? strb4 : 4'b0000;
    end

    always_comb begin
        state_d  = state_q;
        stall    = 1'b1;
        fill_en  = 1'b0;
        wr_en    = 1'b0;
        touch_en = 1'b0;
        case (state_q)
            ST_IDLE: begin
                stall = req_valid;
                if (req_valid) begin
                    if (req.write) begin
                        // write finished last cycle, release the core now
                        if (wr_done_q) begin
                            stall = 1'b0;
                        end else if (lookup.hit) begin
                            state_d = ST_WRITE;
                        end else begin
                            state_d = ST_FILL_LO;
                        end
                    end else if (lookup.hit) begin
                        stall = 1'b0;
                    end else begin
                        state_d = ST_FILL_LO;
                    end
                end
                touch_en = req_valid && !stall && lookup.hit;
            end
            ST_FILL_LO: begin
                if (xfer_done) state_d = ST_FILL_HI;
            end
            ST_FILL_HI: begin
                if (xfer_done) state_d = ST_INSTALL;
            end
            ST_INSTALL: begin
                fill_en = 1'b1;
                state_d = ST_IDLE;
            end
            ST_WRITE: begin
                if (xfer_done) begin
                    wr_en   = lookup.hit;
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            access_q  <= 1'b0;
            wr_done_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            wr_done_q <= (state_q == ST_WRITE) && xfer_done;
            // setup phase lasts one cycle, access holds until pready
            if (apb_req.psel && !access_q) begin
                access_q <= 1'b1;
            end else if (xfer_done) begin
                access_q <= 1'b0;
            end
        end
    end

    // fill words
    always_ff @(posedge clk) begin
        if ((state_q == ST_FILL_LO) && xfer_done) line_lo_q <= apb_rsp.prdata;
        if ((state_q == ST_FILL_HI) && xfer_done) line_hi_q <= apb_rsp.prdata;
    end

    a_setup_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable);

    a_paddr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.psel && !apb_rsp.pready |=> $stable(apb_req.paddr));

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && stall |=> req_valid && $stable(req));

endmodule

`default_nettype wire

/* cache/cache_store.sv */
// two-way set-associative cache storage with tag compare and line updates
`timescale 1ns/1ps
`default_nettype none

`include "dmem_params.svh"

module cache_store
    import cache_pkg::*;
(
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic [`DMEM_ADDR_BITS-1:0]      lookup_addr,
    output cache_lookup_t                        lookup,
    input  wire logic                            fill_en,
    input  wire logic                            fill_way,
    input  wire logic [`DMEM_LINE_BYTES*8-1:0]   fill_data,
    input  wire logic                            wr_en,
    input  wire logic                            wr_way,
    input  wire logic [`DMEM_LINE_BYTES-1:0]     wr_strb,
    input  wire logic [`DMEM_LINE_BYTES*8-1:0]   wr_data,
    input  wire logic                            touch_en
);

    localparam int OFFSET_BITS = $clog2(`DMEM_LINE_BYTES);
    localparam int INDEX_BITS  = $clog2(`DMEM_SETS);

    cache_set_t sets [`DMEM_SETS];

    logic [INDEX_BITS-1:0]     index;
    logic [`DMEM_TAG_BITS-1:0] tag;
    cache_set_t                cur_set;
    logic                      hit0;
    logic                      hit1;
    logic                      sel_way;

    assign index   = lookup_addr[OFFSET_BITS +: INDEX_BITS];
    assign tag     = lookup_addr[`DMEM_ADDR_BITS-1 -: `DMEM_TAG_BITS];
    assign cur_set = sets[index];

    assign hit0 = cur_set.way[0].valid && (cur_set.way[0].tag == tag);
    assign hit1 = cur_set.way[1].valid && (cur_set.way[1].tag == tag);

    // falls back to the lru way on a miss so the controller knows the victim
    assign sel_way = hit0 ? 1'b0 : (hit1 ? 1'b1 : cur_set.lru);

    always_comb begin
        lookup.hit     = hit0 || hit1;
        lookup.hit_way = sel_way;
        // bit 2 picks the upper or lower word of the line
        if (lookup_addr[OFFSET_BITS-1]) begin
            lookup.word = cur_set.way[sel_way].data[63:32];
        end else begin
            lookup.word = cur_set.way[sel_way].data[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `DMEM_SETS; i++) begin
                sets[i].way[0].valid <= 1'b0;
                sets[i].way[1].valid <= 1'b0;
                sets[i].lru          <= 1'b0;
            end
        end else begin
            if (fill_en) begin
                sets[index].way[fill_way].valid <= 1'b1;
                sets[index].way[fill_way].tag   <= tag;
                sets[index].way[fill_way].data  <= fill_data;
                // freshly installed line is most recent
                sets[index].lru                 <= ~fill_way;
            end
            if (wr_en) begin
                for (int b = 0; b < `DMEM_LINE_BYTES; b++) begin
                    if (wr_strb[b]) begin
                        sets[index].way[wr_way].data[b*8 +: 8] <= wr_data[b*8 +: 8];
                    end
                end
            end
            if (touch_en) begin
                sets[index].lru <= ~sel_way;
            end
        end
    end

endmodule

`default_nettype wire

/* common/mem_bus_pkg.sv */
// transaction types for the core request port and the APB memory port
`default_nettype none

`include "dmem_params.svh"

package mem_bus_pkg;

    // access size as issued by the core
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    // wdata is right-aligned, lane placement happens in the cache
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        mem_size_e   size;
        logic        write;
    } core_req_t;

    // requester side of the APB link
    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`DMEM_ADDR_BITS-1:0] paddr;
        logic [31:0]                pwdata;
        logic [3:0]                 pstrb;
    } apb_req_t;

    // completer side of the APB link
    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* common/cache_pkg.sv */
// cache storage types for the two-way data cache
`default_nettype none

`include "dmem_params.svh"

package cache_pkg;

    // one way of a set
    typedef struct packed {
        logic                             valid;
        logic [`DMEM_TAG_BITS-1:0]        tag;
        logic [`DMEM_LINE_BYTES*8-1:0]    data;
    } cache_way_t;

    // lru names the way that gets replaced next
    typedef struct packed {
        cache_way_t [1:0] way;
        logic             lru;
    } cache_set_t;

    // result of the combinational tag compare
    // on a miss hit_way carries the replacement way
    typedef struct packed {
        logic        hit;
        logic        hit_way;
        logic [31:0] word;
    } cache_lookup_t;

endpackage

`default_nettype wire

/* common/dmem_params.svh */
// data memory geometry and cache sizing macros for the data-side subsystem
`ifndef DMEM_PARAMS_SVH
`define DMEM_PARAMS_SVH

// byte address width of the backing RAM (128 KiB)
`define DMEM_ADDR_BITS 17

// cache geometry
`define DMEM_SETS 256
`define DMEM_LINE_BYTES 8

// tag is address bits 16 down to 11
`define DMEM_TAG_BITS 6

// each RAM word starts as its own byte address xor this value
`define DMEM_INIT_PATTERN 32'h5A3C_96E1

`endif
